//--- dv/vmem_stage_tb.sv
// Scalar data at 0x1000..0x10FF and vector data at 0x8000..0x80FF, regions never overlap
`default_nettype none

`include "vmem_params.svh"

module vmem_stage_tb import vlane_pkg::*, dbus_pkg::*; ();

    localparam int N = `VMEM_NUM_LANES;
    localparam int TOTAL_OPS = 40 + 24 + 24 + 16 + 70;  // Sum of operations over all tests

    logic               CLK, reset;
    logic               vuop_valid, vuop_ready, vuop_store;
    vmode_t             vuop_mode;
    veew_t              vuop_eew;
    logic [31:0]        vuop_base, vuop_stride;
    logic [N-1:0][31:0] vuop_index, vuop_wdata;
    logic [N-1:0]       vuop_mask;
    logic               sreq_valid, sreq_ready, sreq_store;
    logic [31:0]        sreq_addr, sreq_wdata;
    load_type_t         sreq_type;
    logic [4:0]         sreq_rd;
    logic               mem_req, mem_we, mem_credit, mem_rsp_valid;
    logic [29:0]        mem_addr;
    logic [31:0]        mem_wdata, mem_rsp_data;
    logic [3:0]         mem_be;
    logic               sload_valid, vwb_valid;
    logic [31:0]        sload_data;
    logic [4:0]         sload_rd;
    logic [N-1:0][31:0] vwb_data;
    logic [N-1:0]       vwb_mask;

    integer     seed = 32'h3d0e;
    int         errors = 0, checks = 0, err_mark = 0, cyc = 0;
    int         outstanding = 0, req_count = 0, last_words = 0;
    int         credit_max, rsp_max;
    logic [31:0] mem [logic [29:0]];      // Memory seen by the DUT
    logic [31:0] ref_mem [logic [29:0]];  // Reference copy
    int          credit_due [$];
    int          rsp_due [$];
    logic [31:0] rsp_data [$];
    logic [31:0] exp_sdata [$];
    logic [4:0]  exp_srd [$];
    logic [N-1:0][31:0] exp_vdata [$];
    logic [N-1:0]       exp_vmask [$];
    load_type_t  ltypes [5] = '{LB, LH, LW, LBU, LHU};

    vmem_stage dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic int unsigned rnd(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Initial contents, every address bit reaches the word
    function automatic logic [31:0] fill(logic [29:0] wa);
        return ({2'b00, wa} * 32'h9e37_79b1) ^ 32'h3c3c_a5a5;
    endfunction

    function automatic logic [31:0] ref_read(logic [31:0] a, int sz);
        logic [31:0] w;
        w = ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : fill(a[31:2]);
        w = w >> (8 * a[1:0]);
        return (sz == 4) ? w : w & ((32'd1 << (8 * sz)) - 1);  // Zero extended
    endfunction

    function automatic void ref_write(logic [31:0] a, logic [31:0] d, int sz);
        logic [31:0] w;
        w = ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : fill(a[31:2]);
        for (int k = 0; k < sz; k++) begin
            w[8 * (a[1:0] + k) +: 8] = d[8 * k +: 8];
        end
        ref_mem[a[31:2]] = w;
    endfunction

    function automatic logic [31:0] lane_addr(vmode_t m, veew_t e, logic [31:0] base,
                                              logic [31:0] stride, logic [31:0] idx, int i);
        case (m)
            VM_STRIDED: return base + stride * i;
            VM_INDEXED: return base + idx;
            default:    return base + i * (1 << e);
        endcase
    endfunction

    function automatic logic [31:0] vbase(veew_t e);
        return 32'h8000 + (rnd(128) & ~((32'd1 << e) - 1));
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // Holds the request until accepted, then updates the reference model
    task automatic send_sreq(input logic store, input load_type_t t);
        int sz;
        logic [31:0] v, wd, addr;
        sz = (t[1:0] == 2'b00) ? 1 : ((t[1:0] == 2'b01) ? 2 : 4);
        addr = 32'h1000 + (rnd(64) & ~(sz - 1));
        wd = $random(seed);
        sreq_valid = 1'b1;
        sreq_store = store;
        sreq_addr = addr;
        sreq_wdata = wd;
        sreq_type = t;
        sreq_rd = 5'(rnd(32));
        while (!sreq_ready) @(negedge CLK);
        if (store) begin
            ref_write(addr, wd, sz);
        end else begin
            v = ref_read(addr, sz);
            if (t == LB) v = {{24{v[7]}}, v[7:0]};
            else if (t == LH) v = {{16{v[15]}}, v[15:0]};
            exp_sdata.push_back(v);
            exp_srd.push_back(sreq_rd);
        end
        @(negedge CLK);
    endtask

    task automatic send_vuop(input logic store, input vmode_t mode, input veew_t eew,
                             input logic [31:0] base, input logic [31:0] stride,
                             input logic [N-1:0][31:0] index, input logic [N-1:0][31:0] wdata,
                             input logic [N-1:0] mask);
        logic [31:0]        a [N];
        logic [N-1:0][31:0] ev;
        logic               fresh;
        int                 sz;
        sz = 1 << eew;
        ev = '0;
        vuop_valid = 1'b1;
        vuop_store = store;
        vuop_mode = mode;
        vuop_eew = eew;
        vuop_base = base;
        vuop_stride = stride;
        vuop_index = index;
        vuop_wdata = wdata;
        vuop_mask = mask;
        while (!vuop_ready) @(negedge CLK);
        last_words = 0;
        for (int i = 0; i < N; i++) begin
            a[i] = lane_addr(mode, eew, base, stride, index[i], i);
            if (mask[i]) begin
                if (store) ref_write(a[i], wdata[i], sz);
                else ev[i] = ref_read(a[i], sz);
                fresh = 1'b1;
                for (int j = 0; j < i; j++) begin
                    if (mask[j] && a[j][31:2] == a[i][31:2]) fresh = 1'b0;  // Word already counted
                end
                if (fresh) last_words++;
            end
        end
        if (!store && mask != '0) begin
            exp_vdata.push_back(ev);
            exp_vmask.push_back(mask);
        end
        @(negedge CLK);
    endtask

    task automatic rand_vuop(input logic store, input vmode_t mode, input veew_t eew,
                             input logic [31:0] base, input logic [N-1:0] mask);
        logic [N-1:0][31:0] index, wdata;
        int                 sz;
        sz = 1 << eew;
        for (int i = 0; i < N; i++) begin
            index[i] = rnd(64) & ~(sz - 1);  // Aligned byte offset
            wdata[i] = $random(seed);
        end
        send_vuop(store, mode, eew, base, sz * rnd(8), index, wdata, mask);
    endtask

    task automatic wait_idle();
        while (exp_sdata.size() != 0 || exp_vmask.size() != 0 || rsp_due.size() != 0
               || outstanding != 0 || !vuop_ready) @(negedge CLK);
    endtask

    // Memory model, credit return and output monitor
    always @(negedge CLK) begin
        logic [31:0]        w;
        logic [4:0]         r;
        logic [N-1:0][31:0] ev;
        logic [N-1:0]       em;
        cyc++;
        mem_credit = 1'b0;
        mem_rsp_valid = 1'b0;
        if (!reset) begin
            if (mem_req) begin
                w = mem.exists(mem_addr) ? mem[mem_addr] : fill(mem_addr);
                if (mem_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_be[b]) w[8 * b +: 8] = mem_wdata[8 * b +: 8];
                    end
                    mem[mem_addr] = w;
                end else begin
                    rsp_data.push_back(w);
                    rsp_due.push_back(cyc + 1 + rnd(rsp_max + 1));
                end
                credit_due.push_back(cyc + 1 + rnd(credit_max + 1));
                req_count++;
            end
            if (credit_due.size() != 0 && credit_due[0] <= cyc) begin
                mem_credit = 1'b1;
                void'(credit_due.pop_front());
            end
            if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin  // In order by construction
                mem_rsp_valid = 1'b1;
                mem_rsp_data = rsp_data.pop_front();
                void'(rsp_due.pop_front());
            end
            outstanding = outstanding + int'(mem_req) - int'(mem_credit);
            if (outstanding > `VMEM_CREDITS) begin
                errors++;
                $display("ERROR: %0d requests outstanding, more than the credits", outstanding);
            end
            if (sload_valid) begin
                if (exp_sdata.size() == 0) begin
                    errors++;
                    $display("ERROR: scalar load result arrived with no load pending");
                end else begin
                    r = exp_srd.pop_front();
                    check("sload_data", exp_sdata.pop_front(), sload_data);
                    check("sload_rd", 32'(r), 32'(sload_rd));
                end
            end
            if (vwb_valid) begin
                if (exp_vmask.size() == 0) begin
                    errors++;
                    $display("ERROR: vector write-back arrived with no vector load pending");
                end else begin
                    em = exp_vmask.pop_front();
                    ev = exp_vdata.pop_front();
                    check("vwb_mask", 32'(em), 32'(vwb_mask));
                    for (int i = 0; i < N; i++) begin
                        if (em[i]) check($sformatf("vwb_data[%0d]", i), ev[i], vwb_data[i]);
                    end
                end
            end
        end
    end

    initial begin
        repeat (TOTAL_OPS * 40 + 20) @(posedge CLK);
        $display("ERROR: timeout, the tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        veew_t       e;
        logic [31:0] base;
        int          req_mark;
        vuop_valid = 1'b0;
        vuop_store = 1'b0;
        vuop_mode = VM_UNIT;
        vuop_eew = EEW8;
        vuop_base = '0;
        vuop_stride = '0;
        vuop_index = '0;
        vuop_wdata = '0;
        vuop_mask = '0;
        sreq_valid = 1'b0;
        sreq_store = 1'b0;
        sreq_addr = '0;
        sreq_wdata = '0;
        sreq_type = LB;
        sreq_rd = '0;
        mem_credit = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        credit_max = 6;
        rsp_max = 6;
        reset = 1'b1;
        repeat (8) @(negedge CLK);
        reset = 1'b0;

        for (int k = 0; k < 16; k++) send_sreq(1'b1, ltypes[rnd(3)]);  // SB, SH, SW
        for (int k = 0; k < 24; k++) send_sreq(1'b0, ltypes[rnd(5)]);
        sreq_valid = 1'b0;
        wait_idle();
        end_test("scalar stores and loads");

        for (int k = 0; k < 24; k++) begin
            e = veew_t'(k / 8);
            base = vbase(e);
            req_mark = req_count;
            rand_vuop(1'b0, VM_UNIT, e, base, 4'(rnd(15) + 1));
            vuop_valid = 1'b0;
            wait_idle();
            check("mem_req count", 32'(last_words), 32'(req_count - req_mark));
        end
        end_test("unit-stride loads");

        for (int k = 0; k < 24; k++) begin
            e = veew_t'(rnd(3));
            rand_vuop(1'b0, (k % 2) ? VM_INDEXED : VM_STRIDED, e, vbase(e), 4'(rnd(15) + 1));
        end
        vuop_valid = 1'b0;
        wait_idle();
        end_test("strided and indexed loads");

        for (int k = 0; k < 8; k++) begin
            e = veew_t'(rnd(3));
            base = vbase(e);
            rand_vuop(1'b1, VM_UNIT, e, base, 4'(rnd(16)));
            rand_vuop(1'b0, VM_UNIT, e, base, 4'hf);  // Reads back the whole group
        end
        vuop_valid = 1'b0;
        wait_idle();
        end_test("masked stores");

        credit_max = 15;  // Long credit delays
        rsp_max = 12;
        fork
            begin
                for (int k = 0; k < 40; k++) send_sreq(rnd(3) == 0, ltypes[rnd(5)]);
                sreq_valid = 1'b0;
            end
            begin
                for (int k = 0; k < 30; k++) begin
                    e = veew_t'(rnd(3));
                    if (rnd(4) == 0) rand_vuop(1'b1, VM_UNIT, e, vbase(e), 4'(rnd(16)));
                    else rand_vuop(1'b0, vmode_t'(rnd(3)), e, vbase(e), 4'(rnd(16)));
                end
                vuop_valid = 1'b0;
            end
        join
        wait_idle();
        end_test("mixed traffic");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
rtl/vlane_pkg.sv
rtl/dbus_pkg.sv
rtl/vector_coalescer.sv
rtl/scalar_access_queue.sv
rtl/load_store_controller.sv
rtl/vmem_stage.sv
dv/vmem_stage_tb.sv

//--- include/vmem_params.svh
// Lane count, credit count and queue depth; credits and queue depth must be powers of two
`ifndef VMEM_PARAMS_SVH
`define VMEM_PARAMS_SVH

// Vector lanes per micro-op
`define VMEM_NUM_LANES 4

// Credits the data memory grants at reset, also the max requests in flight
`define VMEM_CREDITS 4

// Scalar access queue entries
`define VMEM_SQ_DEPTH 4

`endif

//--- rtl/dbus_pkg.sv
// Data-bus types; load types use the RV32 funct3 encoding, responses return in request order
`default_nettype none

`include "vmem_params.svh"

package dbus_pkg;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_type_t;

    // Where a load response goes; a scalar load keeps its byte offset in boff[0]
    typedef struct packed {
        logic                                 vec;
        logic                                 last;  // Last request of a vector micro-op
        logic [`VMEM_NUM_LANES-1:0]           lanes;
        logic [`VMEM_NUM_LANES-1:0][1:0]      boff;
    } rsp_dest_t;

endpackage

`default_nettype wire

//--- rtl/load_store_controller.sv
// Memory must return load data in request order; credit count must be a power of two
`default_nettype none

`include "vmem_params.svh"

module load_store_controller import vlane_pkg::*, dbus_pkg::*; (
    input  logic                                CLK,
    input  logic                                reset,
    input  logic                                vreq_valid,
    output logic                                vreq_ready,
    input  logic [29:0]                         vreq_addr,
    input  logic                                vreq_store,
    input  veew_t                               vreq_eew,
    input  logic [31:0]                         vreq_wdata,
    input  logic [3:0]                          vreq_byte_en,
    input  logic [`VMEM_NUM_LANES-1:0]          vreq_lanes,
    input  logic [`VMEM_NUM_LANES-1:0][1:0]     vreq_boff,
    input  logic                                vreq_last,
    input  logic                                qreq_valid,
    output logic                                qreq_ready,
    input  logic [31:0]                         qreq_addr,
    input  logic                                qreq_store,
    input  logic [31:0]                         qreq_wdata,
    input  logic [3:0]                          qreq_be,
    input  load_type_t                          qreq_type,
    input  logic [4:0]                          qreq_rd,
    output logic                                mem_req,
    output logic [29:0]                         mem_addr,
    output logic                                mem_we,
    output logic [31:0]                         mem_wdata,
    output logic [3:0]                          mem_be,
    input  logic                                mem_credit,
    input  logic                                mem_rsp_valid,
    input  logic [31:0]                         mem_rsp_data,
    output logic                                sload_valid,
    output logic [31:0]                         sload_data,
    output logic [4:0]                          sload_rd,
    output logic                                vwb_valid,
    output logic [`VMEM_NUM_LANES-1:0][31:0]    vwb_data,
    output logic [`VMEM_NUM_LANES-1:0]          vwb_mask
);

    localparam int N  = `VMEM_NUM_LANES;
    localparam int C  = `VMEM_CREDITS;
    localparam int CW = $clog2(C + 1);

    logic [CW-1:0]          credits, ff_count;
    logic                   prio_vec, has_credit, ff_full, grant_v, grant_q, push, pop;
    rsp_dest_t              dest_q [C];
    load_type_t             type_q [C];
    logic [4:0]             rd_q [C];
    logic [$clog2(C)-1:0]   wr_ptr, rd_ptr;
    rsp_dest_t              push_dest, head;
    load_type_t             push_type;
    load_word_u             rsp_word;
    logic [N-1:0]           acc;

    // Vector elements come back zero extended
    function automatic load_type_t eew_type(veew_t eew);
        case (eew)
            EEW8:    return LBU;
            EEW16:   return LHU;
            default: return LW;
        endcase
    endfunction

    function automatic logic [31:0] extract(load_word_u w, load_type_t t, logic [1:0] off);
        case (t)
            LB:      return {{24{w.b[off][7]}}, w.b[off]};
            LBU:     return {24'h0, w.b[off]};
            LH:      return {{16{w.h[off[1]][15]}}, w.h[off[1]]};
            LHU:     return {16'h0, w.h[off[1]]};
            default: return w.b;
        endcase
    endfunction

    assign has_credit = credits != 0;
    assign ff_full = ff_count == C;  // Loads also wait for a free tag slot

    // Round robin, the loser of a tie gets priority next
    assign grant_v = vreq_valid && has_credit && (vreq_store || !ff_full)
                     && (prio_vec || !qreq_valid);
    assign grant_q = qreq_valid && has_credit && (qreq_store || !ff_full) && !grant_v;
    assign vreq_ready = grant_v;
    assign qreq_ready = grant_q;

    assign mem_req   = grant_v || grant_q;
    assign mem_addr  = grant_v ? vreq_addr : qreq_addr[31:2];
    assign mem_we    = grant_v ? vreq_store : qreq_store;
    assign mem_wdata = grant_v ? vreq_wdata : qreq_wdata;
    assign mem_be    = grant_v ? vreq_byte_en : qreq_be;

    always_comb begin
        push_dest.vec   = grant_v;
        push_dest.last  = grant_v && vreq_last;
        push_dest.lanes = grant_v ? vreq_lanes : '0;
        push_dest.boff  = grant_v ? vreq_boff : {{(N-1){2'b00}}, qreq_addr[1:0]};
        push_type = grant_v ? eew_type(vreq_eew) : qreq_type;
    end

    assign push = mem_req && !mem_we;
    assign pop  = mem_rsp_valid;
    assign head = dest_q[rd_ptr];
    assign rsp_word = mem_rsp_data;

    always_ff @(posedge CLK) begin
        if (reset) begin
            credits <= CW'(C);
            prio_vec <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            ff_count <= '0;
            sload_valid <= 1'b0;
            vwb_valid <= 1'b0;
            acc <= '0;
        end else begin
            credits <= credits - CW'(mem_req) + CW'(mem_credit);
            if (grant_v) prio_vec <= 1'b0;
            else if (grant_q) prio_vec <= 1'b1;
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            ff_count <= ff_count + CW'(push) - CW'(pop);
            sload_valid <= pop && !head.vec;
            vwb_valid <= pop && head.vec && head.last;
            if (pop && head.vec) acc <= head.last ? '0 : acc | head.lanes;
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            dest_q[wr_ptr] <= push_dest;
            type_q[wr_ptr] <= push_type;
            rd_q[wr_ptr]   <= qreq_rd;
        end
        if (pop && !head.vec) begin
            sload_data <= extract(rsp_word, type_q[rd_ptr], head.boff[0]);
            sload_rd   <= rd_q[rd_ptr];
        end
        if (pop && head.vec) begin
            for (int i = 0; i < N; i++) begin
                if (head.lanes[i]) vwb_data[i] <= extract(rsp_word, type_q[rd_ptr], head.boff[i]);
            end
            if (head.last) vwb_mask <= acc | head.lanes;
        end
    end

    // Memory returns no more credits than it granted
    assert property (@(posedge CLK) disable iff (reset) credits <= CW'(C));

    // Every response matches an issued load
    assert property (@(posedge CLK) disable iff (reset) mem_rsp_valid |-> ff_count != 0);

endmodule

`default_nettype wire

//--- rtl/scalar_access_queue.sv
// Circular FIFO of scalar accesses; depth must be a power of two, misaligned accesses unsupported
`default_nettype none

`include "vmem_params.svh"

module scalar_access_queue import dbus_pkg::*; (
    input  logic        CLK,
    input  logic        reset,
    input  logic        sreq_valid,
    output logic        sreq_ready,
    input  logic        sreq_store,
    input  logic [31:0] sreq_addr,
    input  logic [31:0] sreq_wdata,
    input  load_type_t  sreq_type,
    input  logic [4:0]  sreq_rd,
    output logic        qreq_valid,
    input  logic        qreq_ready,
    output logic [31:0] qreq_addr,
    output logic        qreq_store,
    output logic [31:0] qreq_wdata,
    output logic [3:0]  qreq_be,
    output load_type_t  qreq_type,
    output logic [4:0]  qreq_rd
);

    localparam int D = `VMEM_SQ_DEPTH;

    logic [31:0]            addr_q [D];
    logic                   store_q [D];
    logic [31:0]            wdata_q [D];
    logic [3:0]             be_q [D];
    load_type_t             type_q [D];
    logic [4:0]             rd_q [D];
    logic [$clog2(D)-1:0]   wr_ptr, rd_ptr;
    logic [$clog2(D+1)-1:0] count;
    logic                   push, pop;
    logic [3:0]             be_in;

    assign sreq_ready = count != D;
    assign push = sreq_valid && sreq_ready;
    assign pop  = qreq_valid && qreq_ready;

    always_comb begin
        case (sreq_type[1:0])
            2'b00:   be_in = 4'b0001 << sreq_addr[1:0];
            2'b01:   be_in = 4'b0011 << sreq_addr[1:0];
            default: be_in = 4'b1111;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            addr_q[wr_ptr]  <= sreq_addr;
            store_q[wr_ptr] <= sreq_store;
            wdata_q[wr_ptr] <= sreq_wdata << {sreq_addr[1:0], 3'b000};  // To byte lane
            be_q[wr_ptr]    <= be_in;
            type_q[wr_ptr]  <= sreq_type;
            rd_q[wr_ptr]    <= sreq_rd;
        end
    end

    assign qreq_valid = count != 0;
    assign qreq_addr  = addr_q[rd_ptr];
    assign qreq_store = store_q[rd_ptr];
    assign qreq_wdata = wdata_q[rd_ptr];
    assign qreq_be    = be_q[rd_ptr];
    assign qreq_type  = type_q[rd_ptr];
    assign qreq_rd    = rd_q[rd_ptr];

    // Accepted access is aligned to its own width
    assert property (@(posedge CLK) disable iff (reset)
        push |-> (sreq_type[1:0] == 2'b00
                  || (sreq_type[1:0] == 2'b01 && !sreq_addr[0])
                  || sreq_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- rtl/vector_coalescer.sv
// One micro-op at a time; elements must be aligned to EEW, so no element crosses a word
`default_nettype none

`include "vmem_params.svh"

module vector_coalescer import vlane_pkg::*; (
    input  logic                                CLK,
    input  logic                                reset,
    input  logic                                vuop_valid,
    output logic                                vuop_ready,
    input  logic                                vuop_store,
    input  vmode_t                              vuop_mode,
    input  veew_t                               vuop_eew,
    input  logic [31:0]                         vuop_base,
    input  logic [31:0]                         vuop_stride,
    input  logic [`VMEM_NUM_LANES-1:0][31:0]    vuop_index,
    input  logic [`VMEM_NUM_LANES-1:0][31:0]    vuop_wdata,
    input  logic [`VMEM_NUM_LANES-1:0]          vuop_mask,
    output logic                                vreq_valid,
    input  logic                                vreq_ready,
    output logic [29:0]                         vreq_addr,
    output logic                                vreq_store,
    output veew_t                               vreq_eew,
    output logic [31:0]                         vreq_wdata,
    output logic [3:0]                          vreq_byte_en,
    output logic [`VMEM_NUM_LANES-1:0]          vreq_lanes,
    output logic [`VMEM_NUM_LANES-1:0][1:0]     vreq_boff,
    output logic                                vreq_last
);

    localparam int N = `VMEM_NUM_LANES;

    logic                   store_q;
    vmode_t                 mode_q;
    veew_t                  eew_q;
    logic [31:0]            base_q, stride_q;
    logic [N-1:0][31:0]     index_q, wdata_q;
    logic [N-1:0]           pending;
    logic [N-1:0][31:0]     lane_addr;
    logic [N-1:0]           group;
    logic [$clog2(N)-1:0]   lead;
    logic [3:0]             ebe, elem_be;
    logic [31:0]            shifted;

    assign ebe = eew_be(eew_q);

    always_comb begin
        for (int i = 0; i < N; i++) begin
            case (mode_q)
                VM_STRIDED: lane_addr[i] = base_q + stride_q * 32'(i);
                VM_INDEXED: lane_addr[i] = base_q + index_q[i];
                default:    lane_addr[i] = base_q + (32'(i) << eew_q);
            endcase
            vreq_boff[i] = lane_addr[i][1:0];
        end

        lead = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (pending[i]) lead = i[$clog2(N)-1:0];  // Lowest pending lane wins
        end

        vreq_wdata = '0;
        vreq_byte_en = '0;
        elem_be = '0;
        shifted = '0;
        for (int i = 0; i < N; i++) begin
            group[i] = pending[i] && (lane_addr[i][31:2] == lane_addr[lead][31:2]);
            elem_be = ebe << lane_addr[i][1:0];
            shifted = wdata_q[i] << {lane_addr[i][1:0], 3'b000};
            if (group[i]) begin
                for (int b = 0; b < 4; b++) begin
                    if (elem_be[b]) vreq_wdata[8*b +: 8] = shifted[8*b +: 8];
                end
                vreq_byte_en = vreq_byte_en | elem_be;
            end
        end
    end

    assign vreq_valid = |pending;
    assign vreq_addr  = lane_addr[lead][31:2];
    assign vreq_lanes = group;
    assign vreq_last  = (pending & ~group) == '0;
    assign vreq_store = store_q;
    assign vreq_eew   = eew_q;

    // Ready is low in reset and rises one cycle after the op drains
    always_ff @(posedge CLK) begin
        if (reset) begin
            vuop_ready <= 1'b0;
            pending <= '0;
        end else if (vuop_ready) begin
            if (vuop_valid) begin
                vuop_ready <= 1'b0;
                pending <= vuop_mask;
            end
        end else if (pending == '0) begin
            vuop_ready <= 1'b1;  // Empty mask or just out of reset
        end else if (vreq_ready) begin
            pending <= pending & ~group;
            vuop_ready <= vreq_last;
        end
    end

    always_ff @(posedge CLK) begin
        if (vuop_valid && vuop_ready) begin
            store_q  <= vuop_store;
            mode_q   <= vuop_mode;
            eew_q    <= vuop_eew;
            base_q   <= vuop_base;
            stride_q <= vuop_stride;
            index_q  <= vuop_index;
            wdata_q  <= vuop_wdata;
        end
    end

    for (genvar g = 0; g < N; g++) begin : g_align
        // Accepted op has every active element aligned to its width
        assert property (@(posedge CLK) disable iff (reset)
            (vuop_valid && vuop_ready) |=> (!pending[g] || (lane_addr[g][1:0] & ebe[2:1]) == 2'b00));
    end

endmodule

`default_nettype wire

//--- rtl/vlane_pkg.sv
// Vector element types; only EEW 8, 16 and 32 are legal, and words are little endian
`default_nettype none

package vlane_pkg;

    typedef enum logic [1:0] {
        EEW8  = 2'd0,
        EEW16 = 2'd1,
        EEW32 = 2'd2
    } veew_t;

    typedef enum logic [1:0] {
        VM_UNIT    = 2'd0,
        VM_STRIDED = 2'd1,
        VM_INDEXED = 2'd2
    } vmode_t;

    // One memory word, read as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } load_word_u;

    // Byte enables of one element at byte offset zero
    function automatic logic [3:0] eew_be(veew_t eew);
        case (eew)
            EEW8:    return 4'b0001;
            EEW16:   return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/vmem_stage.sv
// Memory stage top; no flush, faults or misaligned accesses, scalar and vector share one port
`default_nettype none

`include "vmem_params.svh"

module vmem_stage import vlane_pkg::*, dbus_pkg::*; (
    input  logic                                CLK,
    input  logic                                reset,
    input  logic                                vuop_valid,
    output logic                                vuop_ready,
    input  logic                                vuop_store,
    input  vmode_t                              vuop_mode,
    input  veew_t                               vuop_eew,
    input  logic [31:0]                         vuop_base,
    input  logic [31:0]                         vuop_stride,
    input  logic [`VMEM_NUM_LANES-1:0][31:0]    vuop_index,
    input  logic [`VMEM_NUM_LANES-1:0][31:0]    vuop_wdata,
    input  logic [`VMEM_NUM_LANES-1:0]          vuop_mask,
    input  logic                                sreq_valid,
    output logic                                sreq_ready,
    input  logic                                sreq_store,
    input  logic [31:0]                         sreq_addr,
    input  logic [31:0]                         sreq_wdata,
    input  load_type_t                          sreq_type,
    input  logic [4:0]                          sreq_rd,
    output logic                                mem_req,
    output logic [29:0]                         mem_addr,
    output logic                                mem_we,
    output logic [31:0]                         mem_wdata,
    output logic [3:0]                          mem_be,
    input  logic                                mem_credit,
    input  logic                                mem_rsp_valid,
    input  logic [31:0]                         mem_rsp_data,
    output logic                                sload_valid,
    output logic [31:0]                         sload_data,
    output logic [4:0]                          sload_rd,
    output logic                                vwb_valid,
    output logic [`VMEM_NUM_LANES-1:0][31:0]    vwb_data,
    output logic [`VMEM_NUM_LANES-1:0]          vwb_mask
);

    // Coalescer to controller
    logic                               vreq_valid, vreq_ready, vreq_store, vreq_last;
    logic [29:0]                        vreq_addr;
    veew_t                              vreq_eew;
    logic [31:0]                        vreq_wdata;
    logic [3:0]                         vreq_byte_en;
    logic [`VMEM_NUM_LANES-1:0]         vreq_lanes;
    logic [`VMEM_NUM_LANES-1:0][1:0]    vreq_boff;

    // Queue to controller
    logic                               qreq_valid, qreq_ready, qreq_store;
    logic [31:0]                        qreq_addr, qreq_wdata;
    logic [3:0]                         qreq_be;
    load_type_t                         qreq_type;
    logic [4:0]                         qreq_rd;

    vector_coalescer coalescer_i (
        .CLK, .reset,
        .vuop_valid, .vuop_ready, .vuop_store, .vuop_mode, .vuop_eew,
        .vuop_base, .vuop_stride, .vuop_index, .vuop_wdata, .vuop_mask,
        .vreq_valid, .vreq_ready, .vreq_addr, .vreq_store, .vreq_eew,
        .vreq_wdata, .vreq_byte_en, .vreq_lanes, .vreq_boff, .vreq_last
    );

    scalar_access_queue queue_i (
        .CLK, .reset,
        .sreq_valid, .sreq_ready, .sreq_store, .sreq_addr, .sreq_wdata, .sreq_type, .sreq_rd,
        .qreq_valid, .qreq_ready, .qreq_addr, .qreq_store, .qreq_wdata, .qreq_be,
        .qreq_type, .qreq_rd
    );

    load_store_controller lsc_i (
        .CLK, .reset,
        .vreq_valid, .vreq_ready, .vreq_addr, .vreq_store, .vreq_eew,
        .vreq_wdata, .vreq_byte_en, .vreq_lanes, .vreq_boff, .vreq_last,
        .qreq_valid, .qreq_ready, .qreq_addr, .qreq_store, .qreq_wdata, .qreq_be,
        .qreq_type, .qreq_rd,
        .mem_req, .mem_addr, .mem_we, .mem_wdata, .mem_be,
        .mem_credit, .mem_rsp_valid, .mem_rsp_data,
        .sload_valid, .sload_data, .sload_rd,
        .vwb_valid, .vwb_data, .vwb_mask
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the vmem_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module vmem_stage_tb -Mdir obj_dir -o vmem_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/vmem_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation log has no pass line"
    exit 1
fi
exit 0
